// ==== issue_pkg.sv ====
// shared definitions for the issue and read-operands stage
//   data/pc width, register address and scoreboard tag types
//   functional unit and operator encodings
`default_nettype none

package issue_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned NR_REGS       = 32;
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // ------------------------------------------------------------------
    // functional units and operators
    // ------------------------------------------------------------------
    // NONE also marks an unclobbered register in the scoreboard list
    typedef enum logic [2:0] {
        NONE, LOAD, STORE, ALU, CTRL_FLOW, MULT, CSR
    } fu_t;

    // ADD comes first, it is the reset value of the operator register
    typedef enum logic [3:0] {
        ADD, SUB, XORL, ORL, ANDL, SLL, SRL, SLTS,
        MUL, MULH, DIV, REM,
        LW, SW,
        SFENCE_VMA
    } fu_op_t;

endpackage

`default_nettype wire

// ==== int_regfile.sv ====
// integer register file
//   two combinational read ports, NR_WRITE_PORTS write ports
//   register 0 reads zero, highest-indexed port wins on a collision
`default_nettype none

module int_regfile #(
    parameter int unsigned NR_WRITE_PORTS = 2
) (
    input  wire logic                                         clk_i,
    input  wire logic                                         rst_ni,
    input  wire issue_pkg::reg_addr_t                         raddr_a_i,
    input  wire issue_pkg::reg_addr_t                         raddr_b_i,
    output issue_pkg::xlen_t                                  rdata_a_o,
    output issue_pkg::xlen_t                                  rdata_b_o,
    input  wire issue_pkg::reg_addr_t [NR_WRITE_PORTS-1:0]    waddr_i,
    input  wire issue_pkg::xlen_t     [NR_WRITE_PORTS-1:0]    wdata_i,
    input  wire logic                 [NR_WRITE_PORTS-1:0]    we_i
);

    issue_pkg::xlen_t mem_q [issue_pkg::NR_REGS];

    // write side
    // later ports come later in the loop, so their assignment sticks
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 0; r < issue_pkg::NR_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else begin
            for (int unsigned p = 0; p < NR_WRITE_PORTS; p++) begin
                // x0 is never written and stays at its reset value
                if (we_i[p] && (waddr_i[p] != '0)) begin
                    mem_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // a same-cycle write is not visible on the read side yet
    assign rdata_a_o = mem_q[raddr_a_i];
    assign rdata_b_o = mem_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== operand_hazard.sv ====
// read-after-write check on both source registers
//   forward from the scoreboard when possible, otherwise stall
`default_nettype none

module operand_hazard (
    input  wire issue_pkg::reg_addr_t                     rs1_i,
    input  wire issue_pkg::reg_addr_t                     rs2_i,
    input  wire issue_pkg::fu_op_t                        op_i,
    input  wire logic                                     use_zimm_i,
    input  wire issue_pkg::fu_t [issue_pkg::NR_REGS-1:0]  rd_clobber_i,
    input  wire logic                                     rs1_valid_i,
    input  wire logic                                     rs2_valid_i,
    output logic                                          forward_rs1_o,
    output logic                                          forward_rs2_o,
    output logic                                          stall_o
);

    logic is_sfence;
    logic rs1_clobbered;
    logic rs2_clobbered;

    assign is_sfence = (op_i == issue_pkg::SFENCE_VMA);

    // rs1 carries a zimm, not a register, so nothing to wait for
    assign rs1_clobbered = !use_zimm_i && (rd_clobber_i[rs1_i] != issue_pkg::NONE);
    assign rs2_clobbered = (rd_clobber_i[rs2_i] != issue_pkg::NONE);

    always_comb begin
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        stall_o       = 1'b0;
        // CSR results only reach the operands via the register file,
        // sfence.vma is the exception
        if (rs1_clobbered) begin
            if (rs1_valid_i && ((rd_clobber_i[rs1_i] != issue_pkg::CSR) || is_sfence)) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end
        if (rs2_clobbered) begin
            if (rs2_valid_i && ((rd_clobber_i[rs2_i] != issue_pkg::CSR) || is_sfence)) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== issue_control.sv ====
// issue decision
//   unit busy selection, write-after-write check, acknowledge
`default_nettype none

module issue_control #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic                                         valid_i,
    input  wire issue_pkg::fu_t                               fu_i,
    input  wire logic                                         ex_valid_i,
    input  wire issue_pkg::reg_addr_t                         rd_i,
    input  wire logic                                         stall_i,
    input  wire logic                                         flu_ready_i,
    input  wire logic                                         lsu_ready_i,
    input  wire issue_pkg::fu_t [issue_pkg::NR_REGS-1:0]      rd_clobber_i,
    input  wire issue_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0]   waddr_i,
    input  wire logic [NR_COMMIT_PORTS-1:0]                   we_i,
    input  wire logic                                         mult_pending_i,
    output logic                                              issue_ack_o
);

    logic fu_busy;
    logic rd_free;

    // busy depends on which unit the instruction needs
    always_comb begin
        case (fu_i)
            issue_pkg::ALU, issue_pkg::CTRL_FLOW,
            issue_pkg::CSR, issue_pkg::MULT: fu_busy = !flu_ready_i;
            issue_pkg::LOAD, issue_pkg::STORE: fu_busy = !lsu_ready_i;
            default: fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // write-after-write
    // ------------------------------------------------------------------
    // rd is free when nobody claims it, or a commit port retires it now
    always_comb begin
        rd_free = (rd_clobber_i[rd_i] == issue_pkg::NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (we_i[p] && (waddr_i[p] == rd_i)) begin
                rd_free = 1'b1;
            end
        end
    end

    always_comb begin
        issue_ack_o = 1'b0;
        if (valid_i) begin
            issue_ack_o = !stall_i && !fu_busy && rd_free;
            // exceptions and unit-less instructions need nothing and are taken
            if (ex_valid_i || (fu_i == issue_pkg::NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // the fixed-latency result bus lets only a mult follow a mult
        if (mult_pending_i && (fu_i != issue_pkg::MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== operand_select.sv ====
// operand multiplexer
//   register file or forwarded value, then pc/zimm/imm overrides
`default_nettype none

module operand_select (
    input  wire issue_pkg::xlen_t     rf_a_i,
    input  wire issue_pkg::xlen_t     rf_b_i,
    input  wire issue_pkg::xlen_t     fwd_a_i,
    input  wire issue_pkg::xlen_t     fwd_b_i,
    input  wire logic                 forward_rs1_i,
    input  wire logic                 forward_rs2_i,
    input  wire issue_pkg::xlen_t     pc_i,
    input  wire issue_pkg::reg_addr_t rs1_i,
    input  wire issue_pkg::xlen_t     imm_i,
    input  wire issue_pkg::fu_t       fu_i,
    input  wire logic                 use_pc_i,
    input  wire logic                 use_zimm_i,
    input  wire logic                 use_imm_i,
    output issue_pkg::xlen_t          operand_a_o,
    output issue_pkg::xlen_t          operand_b_o
);

    always_comb begin
        operand_a_o = forward_rs1_i ? fwd_a_i : rf_a_i;
        operand_b_o = forward_rs2_i ? fwd_b_i : rf_b_i;
        // zimm is checked last so it beats the pc
        if (use_pc_i) begin
            operand_a_o = pc_i;
        end
        if (use_zimm_i) begin
            operand_a_o = {{(issue_pkg::XLEN-issue_pkg::REG_ADDR_BITS){1'b0}}, rs1_i};
        end
        // stores and branches keep rs2, their imm travels on imm_o
        if (use_imm_i && (fu_i != issue_pkg::STORE) && (fu_i != issue_pkg::CTRL_FLOW)) begin
            operand_b_o = imm_i;
        end
    end

endmodule

`default_nettype wire

// ==== issue_regs.sv ====
// issue-to-execute pipeline registers
//   data registers load every cycle
//   one-cycle valid strobe for the selected unit, cleared by flush
`default_nettype none

module issue_regs (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 flush_i,
    input  wire logic                 accept_i,
    input  wire logic                 ex_valid_i,
    input  wire issue_pkg::fu_t       fu_i,
    input  wire issue_pkg::fu_op_t    op_i,
    input  wire issue_pkg::trans_id_t trans_id_i,
    input  wire issue_pkg::xlen_t     operand_a_i,
    input  wire issue_pkg::xlen_t     operand_b_i,
    input  wire issue_pkg::xlen_t     imm_i,
    input  wire issue_pkg::xlen_t     pc_i,
    output issue_pkg::xlen_t          operand_a_o,
    output issue_pkg::xlen_t          operand_b_o,
    output issue_pkg::xlen_t          imm_o,
    output issue_pkg::fu_t            fu_o,
    output issue_pkg::fu_op_t         operator_o,
    output issue_pkg::trans_id_t      trans_id_o,
    output issue_pkg::xlen_t          pc_o,
    output logic                      alu_valid_o,
    output logic                      branch_valid_o,
    output logic                      lsu_valid_o,
    output logic                      mult_valid_o,
    output logic                      csr_valid_o,
    output logic                      mult_pending_o
);

    logic mult_valid_q;

    // ------------------------------------------------------------------
    // unit strobes
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_q   <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_q   <= 1'b0;
            csr_valid_o    <= 1'b0;
            // excepted instructions pass through without starting a unit
            if (accept_i && !ex_valid_i && !flush_i) begin
                case (fu_i)
                    issue_pkg::ALU:                    alu_valid_o    <= 1'b1;
                    issue_pkg::CTRL_FLOW:              branch_valid_o <= 1'b1;
                    issue_pkg::LOAD, issue_pkg::STORE: lsu_valid_o    <= 1'b1;
                    issue_pkg::MULT:                   mult_valid_q   <= 1'b1;
                    issue_pkg::CSR:                    csr_valid_o    <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // the mult strobe also feeds back into the issue decision
    assign mult_valid_o   = mult_valid_q;
    assign mult_pending_o = mult_valid_q;

    // ------------------------------------------------------------------
    // data registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            operand_a_o <= '0;
            operand_b_o <= '0;
            imm_o       <= '0;
            fu_o        <= issue_pkg::NONE;
            operator_o  <= issue_pkg::ADD;
            trans_id_o  <= '0;
            pc_o        <= '0;
        end else begin
            operand_a_o <= operand_a_i;
            operand_b_o <= operand_b_i;
            imm_o       <= imm_i;
            fu_o        <= fu_i;
            operator_o  <= op_i;
            trans_id_o  <= trans_id_i;
            pc_o        <= pc_i;
        end
    end

endmodule

`default_nettype wire

// ==== issue_read_operands.sv ====
// issue and read-operands stage, top level
//   register file, hazard check, issue control, operand mux, stage regs
`default_nettype none

module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic                                         clk_i,
    input  wire logic                                         rst_ni,
    input  wire logic                                         flush_i,
    // decoded instruction
    input  wire logic                                         issue_valid_i,
    input  wire issue_pkg::fu_t                               issue_fu_i,
    input  wire issue_pkg::fu_op_t                            issue_op_i,
    input  wire issue_pkg::reg_addr_t                         issue_rs1_i,
    input  wire issue_pkg::reg_addr_t                         issue_rs2_i,
    input  wire issue_pkg::reg_addr_t                         issue_rd_i,
    input  wire issue_pkg::xlen_t                             issue_imm_i,
    input  wire issue_pkg::xlen_t                             issue_pc_i,
    input  wire issue_pkg::trans_id_t                         issue_trans_id_i,
    input  wire logic                                         issue_use_imm_i,
    input  wire logic                                         issue_use_pc_i,
    input  wire logic                                         issue_use_zimm_i,
    input  wire logic                                         issue_ex_valid_i,
    output logic                                              issue_ack_o,
    // scoreboard lookup
    input  wire issue_pkg::fu_t [issue_pkg::NR_REGS-1:0]      rd_clobber_i,
    output issue_pkg::reg_addr_t                              rs1_o,
    output issue_pkg::reg_addr_t                              rs2_o,
    input  wire issue_pkg::xlen_t                             rs1_i,
    input  wire logic                                         rs1_valid_i,
    input  wire issue_pkg::xlen_t                             rs2_i,
    input  wire logic                                         rs2_valid_i,
    // commit ports
    input  wire issue_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0]   waddr_i,
    input  wire issue_pkg::xlen_t     [NR_COMMIT_PORTS-1:0]   wdata_i,
    input  wire logic                 [NR_COMMIT_PORTS-1:0]   we_i,
    // toward execute
    input  wire logic                                         flu_ready_i,
    input  wire logic                                         lsu_ready_i,
    output issue_pkg::xlen_t                                  operand_a_o,
    output issue_pkg::xlen_t                                  operand_b_o,
    output issue_pkg::xlen_t                                  imm_o,
    output issue_pkg::fu_t                                    fu_o,
    output issue_pkg::fu_op_t                                 operator_o,
    output issue_pkg::trans_id_t                              trans_id_o,
    output issue_pkg::xlen_t                                  pc_o,
    output logic                                              alu_valid_o,
    output logic                                              branch_valid_o,
    output logic                                              lsu_valid_o,
    output logic                                              mult_valid_o,
    output logic                                              csr_valid_o
);

    issue_pkg::xlen_t rf_a;
    issue_pkg::xlen_t rf_b;
    issue_pkg::xlen_t operand_a_n;
    issue_pkg::xlen_t operand_b_n;
    logic             forward_rs1;
    logic             forward_rs2;
    logic             stall;
    logic             mult_pending;

    // scoreboard is polled with the raw source fields
    assign rs1_o = issue_rs1_i;
    assign rs2_o = issue_rs2_i;

    int_regfile #(.NR_WRITE_PORTS(NR_COMMIT_PORTS)) i_int_regfile (
        .clk_i, .rst_ni,
        .raddr_a_i (issue_rs1_i), .raddr_b_i (issue_rs2_i),
        .rdata_a_o (rf_a),        .rdata_b_o (rf_b),
        .waddr_i, .wdata_i, .we_i
    );

    operand_hazard i_operand_hazard (
        .rs1_i (issue_rs1_i), .rs2_i (issue_rs2_i), .op_i (issue_op_i),
        .use_zimm_i (issue_use_zimm_i), .rd_clobber_i,
        .rs1_valid_i, .rs2_valid_i,
        .forward_rs1_o (forward_rs1), .forward_rs2_o (forward_rs2), .stall_o (stall)
    );

    issue_control #(.NR_COMMIT_PORTS(NR_COMMIT_PORTS)) i_issue_control (
        .valid_i (issue_valid_i), .fu_i (issue_fu_i), .ex_valid_i (issue_ex_valid_i),
        .rd_i (issue_rd_i), .stall_i (stall), .flu_ready_i, .lsu_ready_i,
        .rd_clobber_i, .waddr_i, .we_i,
        .mult_pending_i (mult_pending), .issue_ack_o
    );

    operand_select i_operand_select (
        .rf_a_i (rf_a), .rf_b_i (rf_b), .fwd_a_i (rs1_i), .fwd_b_i (rs2_i),
        .forward_rs1_i (forward_rs1), .forward_rs2_i (forward_rs2),
        .pc_i (issue_pc_i), .rs1_i (issue_rs1_i), .imm_i (issue_imm_i), .fu_i (issue_fu_i),
        .use_pc_i (issue_use_pc_i), .use_zimm_i (issue_use_zimm_i),
        .use_imm_i (issue_use_imm_i),
        .operand_a_o (operand_a_n), .operand_b_o (operand_b_n)
    );

    issue_regs i_issue_regs (
        .clk_i, .rst_ni, .flush_i,
        .accept_i (issue_valid_i && issue_ack_o),
        .ex_valid_i (issue_ex_valid_i), .fu_i (issue_fu_i), .op_i (issue_op_i),
        .trans_id_i (issue_trans_id_i),
        .operand_a_i (operand_a_n), .operand_b_i (operand_b_n),
        .imm_i (issue_imm_i), .pc_i (issue_pc_i),
        .operand_a_o, .operand_b_o, .imm_o, .fu_o, .operator_o, .trans_id_o, .pc_o,
        .alu_valid_o, .branch_valid_o, .lsu_valid_o, .mult_valid_o, .csr_valid_o,
        .mult_pending_o (mult_pending)
    );

endmodule

`default_nettype wire

// ==== issue_checker.sv ====
// checker for the issue and read-operands stage
//   register file mirror fed from the commit ports
//   reference model of the acknowledge and of the next-cycle outputs
//   scoreboard lookup addresses
//   all comparisons at the falling edge, when inputs are settled
`default_nettype none

module issue_checker #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic clk_i, rst_ni, flush_i,
    input  wire logic issue_valid_i, issue_use_imm_i, issue_use_pc_i,
    input  wire logic issue_use_zimm_i, issue_ex_valid_i, issue_ack_o,
    input  wire logic rs1_valid_i, rs2_valid_i, flu_ready_i, lsu_ready_i,
    input  wire logic alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o,
    input  wire issue_pkg::fu_t       issue_fu_i, fu_o,
    input  wire issue_pkg::fu_op_t    issue_op_i, operator_o,
    input  wire issue_pkg::reg_addr_t issue_rs1_i, issue_rs2_i, issue_rd_i,
    input  wire issue_pkg::reg_addr_t rs1_o, rs2_o,
    input  wire issue_pkg::xlen_t     issue_imm_i, issue_pc_i, rs1_i, rs2_i,
    input  wire issue_pkg::xlen_t     operand_a_o, operand_b_o, imm_o, pc_o,
    input  wire issue_pkg::trans_id_t issue_trans_id_i, trans_id_o,
    input  wire issue_pkg::fu_t       [issue_pkg::NR_REGS-1:0] rd_clobber_i,
    input  wire issue_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0]    waddr_i,
    input  wire issue_pkg::xlen_t     [NR_COMMIT_PORTS-1:0]    wdata_i,
    input  wire logic                 [NR_COMMIT_PORTS-1:0]    we_i,
    output int unsigned errors_o,
    output int unsigned checks_o
);

    issue_pkg::xlen_t     mirror [issue_pkg::NR_REGS];
    issue_pkg::xlen_t     exp_a, exp_b, exp_imm, exp_pc;
    issue_pkg::fu_t       exp_fu;
    issue_pkg::fu_op_t    exp_op;
    issue_pkg::trans_id_t exp_tid;
    // alu, branch, lsu, mult, csr
    logic [4:0]           exp_strobe;

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks_o++;
        if (exp !== act) begin
            errors_o++;
            $display("CHECK FAILED %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    // ------------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------------
    // the scoreboard value is usable, but CSR results only under sfence.vma
    function automatic logic takes_forward(input issue_pkg::reg_addr_t rs, input logic vld);
        return (rd_clobber_i[rs] != issue_pkg::NONE) && vld &&
               ((rd_clobber_i[rs] != issue_pkg::CSR) || (issue_op_i == issue_pkg::SFENCE_VMA));
    endfunction

    function automatic logic must_wait(input issue_pkg::reg_addr_t rs, input logic vld);
        return (rd_clobber_i[rs] != issue_pkg::NONE) && !takes_forward(rs, vld);
    endfunction

    function automatic logic expect_ack(input logic mult_busy);
        logic stall;
        logic busy;
        logic rd_taken;
        stall = must_wait(issue_rs2_i, rs2_valid_i);
        // a zimm in the rs1 field is no register
        if (!issue_use_zimm_i && must_wait(issue_rs1_i, rs1_valid_i)) begin
            stall = 1'b1;
        end
        busy = 1'b0;
        if ((issue_fu_i == issue_pkg::LOAD) || (issue_fu_i == issue_pkg::STORE)) begin
            busy = !lsu_ready_i;
        end else if (issue_fu_i != issue_pkg::NONE) begin
            busy = !flu_ready_i;
        end
        rd_taken = (rd_clobber_i[issue_rd_i] != issue_pkg::NONE);
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (we_i[p] && (waddr_i[p] == issue_rd_i)) begin
                rd_taken = 1'b0;
            end
        end
        if (!issue_valid_i || (mult_busy && (issue_fu_i != issue_pkg::MULT))) begin
            return 1'b0;
        end
        if (issue_ex_valid_i || (issue_fu_i == issue_pkg::NONE)) begin
            return 1'b1;
        end
        return !stall && !busy && !rd_taken;
    endfunction

    function automatic logic [4:0] strobe_for(input issue_pkg::fu_t fu);
        case (fu)
            issue_pkg::ALU:       return 5'b10000;
            issue_pkg::CTRL_FLOW: return 5'b01000;
            issue_pkg::LOAD:      return 5'b00100;
            issue_pkg::STORE:     return 5'b00100;
            issue_pkg::MULT:      return 5'b00010;
            issue_pkg::CSR:       return 5'b00001;
            default:              return 5'b00000;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------------
    always @(negedge clk_i) begin : watch
        logic             ack_ref;
        issue_pkg::xlen_t a;
        issue_pkg::xlen_t b;
        if (!rst_ni) begin
            for (int r = 0; r < issue_pkg::NR_REGS; r++) begin
                mirror[r] = '0;
            end
            exp_a      = '0;
            exp_b      = '0;
            exp_imm    = '0;
            exp_pc     = '0;
            exp_fu     = issue_pkg::NONE;
            exp_op     = issue_pkg::ADD;
            exp_tid    = '0;
            exp_strobe = '0;
        end else begin
            // outputs registered at the last rising edge
            compare("operand_a_o", exp_a, operand_a_o);
            compare("operand_b_o", exp_b, operand_b_o);
            compare("imm_o", exp_imm, imm_o);
            compare("pc_o", exp_pc, pc_o);
            compare("fu_o", exp_fu, fu_o);
            compare("operator_o", exp_op, operator_o);
            compare("trans_id_o", exp_tid, trans_id_o);
            compare("alu_valid_o", exp_strobe[4], alu_valid_o);
            compare("branch_valid_o", exp_strobe[3], branch_valid_o);
            compare("lsu_valid_o", exp_strobe[2], lsu_valid_o);
            compare("mult_valid_o", exp_strobe[1], mult_valid_o);
            compare("csr_valid_o", exp_strobe[0], csr_valid_o);

            // scoreboard is asked about the instruction's own source fields
            compare("rs1_o", issue_rs1_i, rs1_o);
            compare("rs2_o", issue_rs2_i, rs2_o);

            ack_ref = expect_ack(exp_strobe[1]);
            compare("issue_ack_o", ack_ref, issue_ack_o);

            // what the next rising edge should register
            a = mirror[issue_rs1_i];
            if (!issue_use_zimm_i && takes_forward(issue_rs1_i, rs1_valid_i)) begin
                a = rs1_i;
            end
            if (issue_use_pc_i) begin
                a = issue_pc_i;
            end
            if (issue_use_zimm_i) begin
                a = {27'd0, issue_rs1_i};
            end
            b = takes_forward(issue_rs2_i, rs2_valid_i) ? rs2_i : mirror[issue_rs2_i];
            if (issue_use_imm_i && (issue_fu_i != issue_pkg::STORE) &&
                (issue_fu_i != issue_pkg::CTRL_FLOW)) begin
                b = issue_imm_i;
            end
            exp_a      = a;
            exp_b      = b;
            exp_imm    = issue_imm_i;
            exp_pc     = issue_pc_i;
            exp_fu     = issue_fu_i;
            exp_op     = issue_op_i;
            exp_tid    = issue_trans_id_i;
            exp_strobe = '0;
            if (issue_valid_i && ack_ref && !issue_ex_valid_i && !flush_i) begin
                exp_strobe = strobe_for(issue_fu_i);
            end

            // commits land at the next edge, later ports overwrite earlier ones
            for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (we_i[p] && (waddr_i[p] != '0)) begin
                    mirror[waddr_i[p]] = wdata_i[p];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_issue_read_operands.sv ====
// testbench for the issue and read-operands stage
//   clock, reset, register preload through the commit ports
//   random instructions held until acknowledged, random scoreboard state
//   DUT instance and the checker that watches it
`default_nettype none

module tb_issue_read_operands;

    localparam int unsigned NR_COMMIT_PORTS = 2;
    // cycles an instruction may wait for its acknowledge
    localparam int unsigned ACK_LIMIT       = 200;
    localparam int unsigned NR_INSTR        = 600;

    // signals carry the DUT port names, both instances connect by name
    logic clk_i, rst_ni, flush_i;
    logic issue_valid_i, issue_use_imm_i, issue_use_pc_i, issue_use_zimm_i, issue_ex_valid_i;
    logic issue_ack_o, rs1_valid_i, rs2_valid_i, flu_ready_i, lsu_ready_i;
    logic alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o;
    issue_pkg::fu_t       issue_fu_i, fu_o;
    issue_pkg::fu_op_t    issue_op_i, operator_o;
    issue_pkg::reg_addr_t issue_rs1_i, issue_rs2_i, issue_rd_i, rs1_o, rs2_o;
    issue_pkg::xlen_t     issue_imm_i, issue_pc_i, rs1_i, rs2_i;
    issue_pkg::xlen_t     operand_a_o, operand_b_o, imm_o, pc_o;
    issue_pkg::trans_id_t issue_trans_id_i, trans_id_o;
    issue_pkg::fu_t       [issue_pkg::NR_REGS-1:0]  rd_clobber_i;
    issue_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0]     waddr_i;
    issue_pkg::xlen_t     [NR_COMMIT_PORTS-1:0]     wdata_i;
    logic                 [NR_COMMIT_PORTS-1:0]     we_i;
    int unsigned          error_count, check_count;
    integer               seed;
    issue_pkg::reg_addr_t next_rd;
    logic                 timed_out;

    issue_read_operands #(.NR_COMMIT_PORTS(NR_COMMIT_PORTS)) i_issue_read_operands (.*);

    issue_checker #(.NR_COMMIT_PORTS(NR_COMMIT_PORTS)) i_issue_checker (
        .*, .errors_o (error_count), .checks_o (check_count)
    );

    always #20 clk_i = ~clk_i;

    function automatic int unsigned roll(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    // every even register on port 0, every odd one on port 1
    task automatic preload_registers();
        for (int r = 0; r < issue_pkg::NR_REGS; r += 2) begin
            @(posedge clk_i);
            we_i       <= '1;
            waddr_i[0] <= issue_pkg::reg_addr_t'(r);
            wdata_i[0] <= 32'h1000_0000 + r * 32'h0001_0101;
            waddr_i[1] <= issue_pkg::reg_addr_t'(r + 1);
            wdata_i[1] <= 32'h1000_0000 + (r + 1) * 32'h0001_0101;
        end
        // both ports on x5, port 1 has to win
        @(posedge clk_i);
        waddr_i[0] <= 5'd5;
        wdata_i[0] <= 32'hdead_0005;
        waddr_i[1] <= 5'd5;
        wdata_i[1] <= 32'hbeef_0005;
        @(posedge clk_i);
        we_i <= '0;
    endtask

    task automatic draw_instruction();
        next_rd = issue_pkg::reg_addr_t'(roll(32));
        issue_valid_i    <= 1'b1;
        issue_fu_i       <= issue_pkg::fu_t'(roll(7));
        issue_op_i       <= issue_pkg::fu_op_t'(roll(15));
        issue_rs1_i      <= issue_pkg::reg_addr_t'(roll(32));
        issue_rs2_i      <= issue_pkg::reg_addr_t'(roll(32));
        issue_rd_i       <= next_rd;
        issue_imm_i      <= $random(seed);
        issue_pc_i       <= $random(seed);
        issue_trans_id_i <= issue_pkg::trans_id_t'(roll(8));
        issue_use_imm_i  <= (roll(2) == 1);
        issue_use_pc_i   <= (roll(4) == 0);
        issue_use_zimm_i <= (roll(6) == 0);
        issue_ex_valid_i <= (roll(10) == 0);
    endtask

    // scoreboard, commit ports, ready lines and flush change every cycle
    task automatic stir_environment();
        // x0 is never a destination in flight
        for (int r = 1; r < issue_pkg::NR_REGS; r++) begin
            if (roll(5) == 0) begin
                rd_clobber_i[r] <= issue_pkg::fu_t'(1 + roll(6));
            end else begin
                rd_clobber_i[r] <= issue_pkg::NONE;
            end
        end
        rs1_i       <= $random(seed);
        rs2_i       <= $random(seed);
        rs1_valid_i <= (roll(2) == 1);
        rs2_valid_i <= (roll(2) == 1);
        flu_ready_i <= (roll(4) != 0);
        lsu_ready_i <= (roll(4) != 0);
        flush_i     <= (roll(8) == 0);
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            we_i[p]    <= (roll(2) == 1);
            // now and then retire exactly the pending destination
            waddr_i[p] <= (roll(3) == 0) ? next_rd : issue_pkg::reg_addr_t'(roll(32));
            wdata_i[p] <= $random(seed);
        end
    endtask

    // ack is settled at the falling edge, acceptance is the next rising edge
    task automatic wait_for_ack(input int n);
        int unsigned waited;
        waited = 0;
        @(negedge clk_i);
        while (!issue_ack_o && waited < ACK_LIMIT) begin
            @(posedge clk_i);
            stir_environment();
            @(negedge clk_i);
            waited++;
        end
        if (!issue_ack_o) begin
            $display("instruction %0d was not acknowledged within %0d cycles", n, ACK_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        seed             = 32'h4a6e2a10;
        timed_out        = 1'b0;
        next_rd          = '0;
        flush_i          = 1'b0;
        issue_valid_i    = 1'b0;
        issue_fu_i       = issue_pkg::NONE;
        issue_op_i       = issue_pkg::ADD;
        issue_rs1_i      = '0;
        issue_rs2_i      = '0;
        issue_rd_i       = '0;
        issue_imm_i      = '0;
        issue_pc_i       = '0;
        issue_trans_id_i = '0;
        issue_use_imm_i  = 1'b0;
        issue_use_pc_i   = 1'b0;
        issue_use_zimm_i = 1'b0;
        issue_ex_valid_i = 1'b0;
        for (int r = 0; r < issue_pkg::NR_REGS; r++) begin
            rd_clobber_i[r] = issue_pkg::NONE;
        end
        rs1_i            = '0;
        rs2_i            = '0;
        rs1_valid_i      = 1'b0;
        rs2_valid_i      = 1'b0;
        waddr_i          = '0;
        wdata_i          = '0;
        we_i             = '0;
        flu_ready_i      = 1'b1;
        lsu_ready_i      = 1'b1;

        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        preload_registers();

        for (int n = 0; n < NR_INSTR && !timed_out; n++) begin
            @(posedge clk_i);
            // an idle cycle now and then
            if (roll(5) == 0) begin
                issue_valid_i <= 1'b0;
                stir_environment();
                @(posedge clk_i);
            end
            draw_instruction();
            stir_environment();
            wait_for_ack(n);
        end
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        repeat (3) @(posedge clk_i);

        $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
issue_pkg.sv
int_regfile.sv
operand_hazard.sv
issue_control.sv
operand_select.sv
issue_regs.sv
issue_read_operands.sv
issue_checker.sv
tb_issue_read_operands.sv
